/* common/conv_acc_pkg.sv */
package conv_acc_pkg;

  localparam int ADDR_W = 8;
  localparam int PIX_W  = 8;
  localparam int BIAS_W = 16;
  localparam int OUT_W  = 32;

  // Values outside this set leave the accelerator idle
  typedef enum logic [3:0] {
    MODE_CONV_1X1 = 4'd1,
    MODE_CONV_3X3 = 4'd2,
    MODE_MAX_POOL = 4'd3
  } acc_mode_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_RUN,
    ST_WRITE,
    ST_DONE
  } eng_state_e;

  // One access to a single-port SRAM
  typedef struct packed {
    logic              en;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [OUT_W-1:0]  wdata;
  } mem_req_t;

  // All four memories of one engine, ifm/ofm are the image and result memories
  typedef struct packed {
    mem_req_t bias;
    mem_req_t weight;
    mem_req_t ifm;
    mem_req_t ofm;
  } eng_req_t;

endpackage

/* conv/conv_1x1.sv */
module conv_1x1 #(
  parameter int IMG_W = 6,
  parameter int IMG_H = 6
) (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            start_i,
  input  logic [31:0]                     w8_i,
  output logic                            finish_o,
  output conv_acc_pkg::eng_req_t          req_o,
  input  logic [conv_acc_pkg::OUT_W-1:0]  bias_rdata_i,
  input  logic [conv_acc_pkg::OUT_W-1:0]  weight_rdata_i,
  input  logic [conv_acc_pkg::OUT_W-1:0]  in_rdata_i
);

  localparam int AW     = conv_acc_pkg::ADDR_W;
  localparam int PW     = conv_acc_pkg::PIX_W;
  localparam int N_PIX  = IMG_W * IMG_H;

  conv_acc_pkg::eng_state_e               state_q;
  logic [AW-1:0]                          pix_q;
  logic                                   bias_vld_q;
  logic signed [PW-1:0]                   w_q;
  logic signed [conv_acc_pkg::BIAS_W-1:0] bias_q;
  logic signed [2*PW-1:0]                 prod;
  logic signed [conv_acc_pkg::OUT_W-1:0]  res;

  assign prod = $signed(in_rdata_i[PW-1:0]) * w_q;
  assign res  = bias_q + prod;

  // Weight memory is never read here
  always_comb begin
    req_o = '0;
    case (state_q)
      conv_acc_pkg::ST_LOAD: req_o.bias.en = 1'b1;
      conv_acc_pkg::ST_RUN: begin
        req_o.ifm.en   = 1'b1;
        req_o.ifm.addr = pix_q;
      end
      conv_acc_pkg::ST_WRITE: begin
        req_o.ofm.en    = 1'b1;
        req_o.ofm.we    = 1'b1;
        req_o.ofm.addr  = pix_q;
        req_o.ofm.wdata = res;
      end
      default: req_o = '0;
    endcase
  end

  assign finish_o = (state_q == conv_acc_pkg::ST_DONE);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= conv_acc_pkg::ST_IDLE;
      pix_q      <= '0;
      bias_vld_q <= 1'b0;
    end else begin
      bias_vld_q <= (state_q == conv_acc_pkg::ST_LOAD);
      case (state_q)
        conv_acc_pkg::ST_IDLE: begin
          if (start_i) begin
            state_q <= conv_acc_pkg::ST_LOAD;
            pix_q   <= '0;
          end
        end
        conv_acc_pkg::ST_LOAD:  state_q <= conv_acc_pkg::ST_RUN;
        conv_acc_pkg::ST_RUN:   state_q <= conv_acc_pkg::ST_WRITE;
        conv_acc_pkg::ST_WRITE: begin
          pix_q   <= pix_q + 1'b1;
          state_q <= (pix_q == AW'(N_PIX - 1)) ? conv_acc_pkg::ST_DONE : conv_acc_pkg::ST_RUN;
        end
        default: state_q <= conv_acc_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == conv_acc_pkg::ST_IDLE && start_i) begin
      w_q <= $signed(w8_i[PW-1:0]);
    end
    if (bias_vld_q) begin
      bias_q <= $signed(bias_rdata_i[conv_acc_pkg::BIAS_W-1:0]);
    end
  end

  // Each write follows its own pixel read
  a_write_pair: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_o.ofm.we |-> $past(req_o.ifm.en) && $past(req_o.ifm.addr) == req_o.ofm.addr);

endmodule

/* conv/conv_3x3.sv */
module conv_3x3 #(
  parameter int IMG_W = 6,
  parameter int IMG_H = 6
) (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            start_i,
  output logic                            finish_o,
  output conv_acc_pkg::eng_req_t          req_o,
  input  logic [conv_acc_pkg::OUT_W-1:0]  bias_rdata_i,
  input  logic [conv_acc_pkg::OUT_W-1:0]  weight_rdata_i,
  input  logic [conv_acc_pkg::OUT_W-1:0]  in_rdata_i
);

  localparam int AW       = conv_acc_pkg::ADDR_W;
  localparam int PW       = conv_acc_pkg::PIX_W;
  localparam int OUT_COLS = IMG_W - 2;
  localparam int OUT_ROWS = IMG_H - 2;

  conv_acc_pkg::eng_state_e              state_q;
  logic [3:0]                            cnt_q;
  logic [3:0]                            tap_d_q;
  logic                                  ld_vld_q;
  logic                                  mac_vld_q;
  logic [AW-1:0]                         row_q;
  logic [AW-1:0]                         col_q;
  logic signed [conv_acc_pkg::BIAS_W-1:0] bias_q;
  logic signed [PW-1:0]                  w_q [9];
  logic signed [conv_acc_pkg::OUT_W-1:0] acc_q;
  logic signed [2*PW-1:0]                mac;
  logic signed [conv_acc_pkg::OUT_W-1:0] acc_sum;
  logic [AW-1:0]                         tap_addr;
  logic [AW-1:0]                         out_addr;
  logic                                  last_col;
  logic                                  last_row;

  // Tap index cnt_q walks the window row-major
  assign tap_addr = AW'((row_q + cnt_q / 4'd3) * IMG_W + col_q + cnt_q % 4'd3);
  assign out_addr = AW'(row_q * OUT_COLS + col_q);
  assign last_col = (col_q == AW'(OUT_COLS - 1));
  assign last_row = (row_q == AW'(OUT_ROWS - 1));

  assign mac     = $signed(in_rdata_i[PW-1:0]) * w_q[tap_d_q];
  assign acc_sum = acc_q + mac;

  always_comb begin
    req_o = '0;
    case (state_q)
      conv_acc_pkg::ST_LOAD: begin
        if (cnt_q == 4'd0) begin
          req_o.bias.en = 1'b1;
        end else begin
          req_o.weight.en   = 1'b1;
          req_o.weight.addr = AW'(cnt_q - 4'd1);
        end
      end
      conv_acc_pkg::ST_RUN: begin
        req_o.ifm.en   = 1'b1;
        req_o.ifm.addr = tap_addr;
      end
      conv_acc_pkg::ST_WRITE: begin
        req_o.ofm.en    = 1'b1;
        req_o.ofm.we    = 1'b1;
        req_o.ofm.addr  = out_addr;
        req_o.ofm.wdata = acc_sum;
      end
      default: req_o = '0;
    endcase
  end

  assign finish_o = (state_q == conv_acc_pkg::ST_DONE);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= conv_acc_pkg::ST_IDLE;
      cnt_q     <= '0;
      tap_d_q   <= '0;
      ld_vld_q  <= 1'b0;
      mac_vld_q <= 1'b0;
      row_q     <= '0;
      col_q     <= '0;
    end else begin
      ld_vld_q  <= (state_q == conv_acc_pkg::ST_LOAD);
      mac_vld_q <= (state_q == conv_acc_pkg::ST_RUN);
      tap_d_q   <= cnt_q;
      case (state_q)
        conv_acc_pkg::ST_IDLE: begin
          if (start_i) begin
            state_q <= conv_acc_pkg::ST_LOAD;
            cnt_q   <= '0;
            row_q   <= '0;
            col_q   <= '0;
          end
        end
        conv_acc_pkg::ST_LOAD: begin
          // Bias at 0, weights at 1 to 9
          if (cnt_q == 4'd9) begin
            cnt_q   <= '0;
            state_q <= conv_acc_pkg::ST_RUN;
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
        conv_acc_pkg::ST_RUN: begin
          if (cnt_q == 4'd8) begin
            cnt_q   <= '0;
            state_q <= conv_acc_pkg::ST_WRITE;
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
        conv_acc_pkg::ST_WRITE: begin
          if (last_col) begin
            col_q <= '0;
            row_q <= row_q + 1'b1;
          end else begin
            col_q <= col_q + 1'b1;
          end
          state_q <= (last_col && last_row) ? conv_acc_pkg::ST_DONE : conv_acc_pkg::ST_RUN;
        end
        default: state_q <= conv_acc_pkg::ST_IDLE;
      endcase
    end
  end

  // Read data lands one cycle after the request
  always_ff @(posedge clk) begin
    if (ld_vld_q) begin
      if (tap_d_q == 4'd0) begin
        bias_q <= $signed(bias_rdata_i[conv_acc_pkg::BIAS_W-1:0]);
        acc_q  <= $signed(bias_rdata_i[conv_acc_pkg::BIAS_W-1:0]);
      end else begin
        w_q[tap_d_q - 4'd1] <= $signed(weight_rdata_i[PW-1:0]);
      end
    end
    if (state_q == conv_acc_pkg::ST_WRITE) begin
      acc_q <= bias_q;
    end else if (mac_vld_q) begin
      acc_q <= acc_sum;
    end
  end

  a_out_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_o.ofm.en && req_o.ofm.we |-> req_o.ofm.addr < AW'(OUT_COLS * OUT_ROWS));

endmodule

/* dv/tb_conv_acc.sv */
module tb_conv_acc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IMG_W  = 6;
  localparam int IMG_H  = 6;
  localparam int OW     = conv_acc_pkg::OUT_W;
  localparam int N_PIX  = IMG_W * IMG_H;
  localparam int N_3X3  = (IMG_W - 2) * (IMG_H - 2);
  localparam int N_POOL = (IMG_W / 2) * (IMG_H / 2);

  // Worst-case cycles of one run per engine, launch included
  localparam int CYC_3X3     = 10 + 10 * N_3X3 + 4;
  localparam int CYC_1X1     = 1 + 2 * N_PIX + 4;
  localparam int CYC_POOL    = 5 * N_POOL + 4;
  localparam int IDLE_WIN    = 200;
  localparam int TEST_CYC    = 10 + 2 * CYC_3X3 + 2 * CYC_1X1 + CYC_POOL + IDLE_WIN + 60;
  localparam int WATCHDOG_NS = 2 * TEST_CYC * 10;

  logic                    clk = 1'b0;
  logic                    rst_n_i;
  logic                    start_i;
  conv_acc_pkg::acc_mode_e mode_i;
  logic [31:0]             w8_i;
  conv_acc_pkg::mem_req_t  bias_req;
  conv_acc_pkg::mem_req_t  weight_req;
  conv_acc_pkg::mem_req_t  in_req;
  conv_acc_pkg::mem_req_t  out_req;
  logic [OW-1:0]           bias_rdata = '0;
  logic [OW-1:0]           weight_rdata = '0;
  logic [OW-1:0]           in_rdata = '0;
  logic                    finish_o;

  logic [OW-1:0] bias_mem [256];
  logic [OW-1:0] weight_mem [256];
  logic [OW-1:0] in_mem [256];
  logic [OW-1:0] out_mem [256];
  logic [OW-1:0] exp_mem [256];
  logic          clear_out = 1'b0;
  int            write_count = 0;
  int            finish_count = 0;

  logic [31:0] lfsr_q = 32'h5fb29617;
  logic [31:0] w8_val;
  string       test_name;
  int          err_count = 0;
  int          test_errs = 0;
  int          pass_tests = 0;
  int          fail_tests = 0;

  always #5 clk = ~clk;

  conv_acc #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) u_conv_acc (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .start_i        (start_i),
    .mode_i         (mode_i),
    .w8_i           (w8_i),
    .bias_req_o     (bias_req),
    .weight_req_o   (weight_req),
    .in_req_o       (in_req),
    .out_req_o      (out_req),
    .bias_rdata_i   (bias_rdata),
    .weight_rdata_i (weight_rdata),
    .in_rdata_i     (in_rdata),
    .finish_o       (finish_o)
  );

  // Single-port memories, read data one cycle after the request
  always @(posedge clk) begin
    if (bias_req.en && !bias_req.we) bias_rdata <= bias_mem[bias_req.addr];
    if (weight_req.en && !weight_req.we) weight_rdata <= weight_mem[weight_req.addr];
    if (in_req.en && !in_req.we) in_rdata <= in_mem[in_req.addr];
    if (clear_out) begin
      for (int a = 0; a < 256; a++) out_mem[a] <= {24'hc0de00, 8'(a)};
    end else if (out_req.en && out_req.we) begin
      out_mem[out_req.addr] <= out_req.wdata;
      write_count <= write_count + 1;
    end
    if (finish_o) finish_count <= finish_count + 1;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int s8(input logic [OW-1:0] x);
    return int'($signed(x[7:0]));
  endfunction

  task automatic check_word(input string what, input logic [OW-1:0] exp_v,
                            input logic [OW-1:0] act_v);
    if (exp_v !== act_v) begin
      err_count++;
      $display("error %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic check_bit(input string what, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      err_count++;
      $display("error %s: %s expected %b actual %b", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic check_count(input string what, input int exp_v, input int act_v);
    if (exp_v != act_v) begin
      err_count++;
      $display("error %s: %s expected %0d actual %0d", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = err_count;
  endtask

  task automatic end_test();
    if (err_count == test_errs) begin
      pass_tests++;
      $display("test %s: pass", test_name);
    end else begin
      fail_tests++;
      $display("test %s: FAIL with %0d errors", test_name, err_count - test_errs);
    end
  endtask

  task automatic fill_inputs();
    logic [31:0] r;
    r = rand_bits(16);
    bias_mem[0] = {{16{r[15]}}, r[15:0]};
    for (int i = 0; i < 9; i++) begin
      r = rand_bits(8);
      weight_mem[i] = {{24{r[7]}}, r[7:0]};
    end
    for (int p = 0; p < N_PIX; p++) begin
      r = rand_bits(8);
      in_mem[p] = {{24{r[7]}}, r[7:0]};
    end
  endtask

  task automatic model_3x3();
    int acc;
    for (int r = 0; r < IMG_H - 2; r++) begin
      for (int c = 0; c < IMG_W - 2; c++) begin
        acc = int'($signed(bias_mem[0][15:0]));
        for (int k = 0; k < 9; k++) begin
          acc += s8(in_mem[(r + k / 3) * IMG_W + c + k % 3]) * s8(weight_mem[k]);
        end
        exp_mem[r * (IMG_W - 2) + c] = acc;
      end
    end
  endtask

  task automatic model_1x1();
    for (int p = 0; p < N_PIX; p++) begin
      exp_mem[p] = int'($signed(bias_mem[0][15:0])) + s8(in_mem[p]) * s8(w8_val);
    end
  endtask

  task automatic model_pool();
    int m;
    int v;
    for (int r = 0; r < IMG_H / 2; r++) begin
      for (int c = 0; c < IMG_W / 2; c++) begin
        m = -129;
        for (int k = 0; k < 4; k++) begin
          v = s8(in_mem[(2 * r + k / 2) * IMG_W + 2 * c + k % 2]);
          if (v > m) m = v;
        end
        exp_mem[r * (IMG_W / 2) + c] = m;
      end
    end
  endtask

  task automatic clear_outputs();
    @(posedge clk);
    clear_out <= 1'b1;
    @(posedge clk);
    clear_out <= 1'b0;
  endtask

  task automatic launch(input conv_acc_pkg::acc_mode_e m);
    @(posedge clk);
    mode_i  <= m;
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic wait_finish(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!finish_o && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!finish_o) begin
      err_count++;
      $display("%s: the DUT gave no finish pulse within %0d cycles", test_name, limit);
    end
  endtask

  // Launch, optionally disturb with a new mode and a second start, then check
  task automatic run_and_check(input conv_acc_pkg::acc_mode_e m, input int n_out,
                               input int limit, input bit disturb);
    int w0;
    int f0;
    clear_outputs();
    w0 = write_count;
    f0 = finish_count;
    launch(m);
    if (disturb) begin
      repeat (20) @(posedge clk);
      mode_i  <= conv_acc_pkg::MODE_CONV_1X1;
      start_i <= 1'b1;
      @(posedge clk);
      start_i <= 1'b0;
    end
    wait_finish(limit);
    check_count("writes at finish", n_out, write_count - w0);
    repeat (3) @(negedge clk);
    check_count("finish pulses", 1, finish_count - f0);
    for (int a = 0; a < n_out; a++) begin
      check_word($sformatf("word %0d", a), exp_mem[a], out_mem[a]);
    end
  endtask

  task automatic run_1x1(input int limit);
    fill_inputs();
    w8_val = rand_bits(32);
    @(posedge clk);
    w8_i <= w8_val;
    model_1x1();
    run_and_check(conv_acc_pkg::MODE_CONV_1X1, N_PIX, limit, 1'b0);
  endtask

  initial begin
    int w0;
    int f0;
    int a;
    rst_n_i = 1'b0;
    start_i = 1'b0;
    mode_i  = conv_acc_pkg::MODE_CONV_1X1;
    w8_i    = '0;
    w8_val  = '0;
    for (int i = 0; i < 256; i++) begin
      bias_mem[i]   = {24'hb1a500, 8'(i)};
      weight_mem[i] = {24'h3e1600, 8'(i)};
      in_mem[i]     = {24'h1a9e00, 8'(i)};
    end
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;

    begin_test("reset");
    @(negedge clk);
    check_bit("finish_o", 1'b0, finish_o);
    check_bit("bias en", 1'b0, bias_req.en);
    check_bit("weight en", 1'b0, weight_req.en);
    check_bit("input en", 1'b0, in_req.en);
    check_bit("output en", 1'b0, out_req.en);
    check_bit("output we", 1'b0, out_req.we);
    end_test();

    begin_test("conv_3x3");
    fill_inputs();
    model_3x3();
    run_and_check(conv_acc_pkg::MODE_CONV_3X3, N_3X3, CYC_3X3, 1'b0);
    end_test();

    begin_test("conv_1x1");
    run_1x1(CYC_1X1);
    end_test();

    begin_test("max_pool");
    fill_inputs();
    // One window made of negative pixels only
    for (int k = 0; k < 4; k++) begin
      a = (2 + k / 2) * IMG_W + 2 + k % 2;
      in_mem[a] = in_mem[a] | 32'hffffff80;
    end
    model_pool();
    run_and_check(conv_acc_pkg::MODE_MAX_POOL, N_POOL, CYC_POOL, 1'b0);
    end_test();

    begin_test("invalid_mode");
    w0 = write_count;
    f0 = finish_count;
    launch(conv_acc_pkg::acc_mode_e'(4'd9));
    repeat (IDLE_WIN) @(negedge clk);
    check_count("writes", 0, write_count - w0);
    check_count("finish pulses", 0, finish_count - f0);
    end_test();

    begin_test("busy_ignore");
    fill_inputs();
    model_3x3();
    run_and_check(conv_acc_pkg::MODE_CONV_3X3, N_3X3, CYC_3X3, 1'b1);
    run_1x1(CYC_1X1);
    end_test();

    $display("tests passed %0d, tests with errors %0d", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("The run timed out after %0d ns without reaching the end", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* files.f */
common/conv_acc_pkg.sv
source/accel_router.sv
conv/conv_3x3.sv
conv/conv_1x1.sv
source/max_pool.sv
source/conv_acc.sv
dv/tb_conv_acc.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_acc -f files.f \
  > sim.log 2>&1 && ./obj_dir/Vtb_conv_acc >> sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* source/accel_router.sv */
module accel_router (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  conv_acc_pkg::acc_mode_e   mode_i,
  output logic                      start_1x1_o,
  output logic                      start_3x3_o,
  output logic                      start_pool_o,
  input  logic                      finish_1x1_i,
  input  logic                      finish_3x3_i,
  input  logic                      finish_pool_i,
  input  conv_acc_pkg::eng_req_t    req_1x1_i,
  input  conv_acc_pkg::eng_req_t    req_3x3_i,
  input  conv_acc_pkg::eng_req_t    req_pool_i,
  output conv_acc_pkg::mem_req_t    bias_req_o,
  output conv_acc_pkg::mem_req_t    weight_req_o,
  output conv_acc_pkg::mem_req_t    in_req_o,
  output conv_acc_pkg::mem_req_t    out_req_o,
  output logic                      finish_o
);

  logic                     busy_q;
  conv_acc_pkg::acc_mode_e  mode_q;
  logic                     mode_ok;
  logic                     accept;
  conv_acc_pkg::eng_req_t   sel_req;

  assign mode_ok = mode_i inside {conv_acc_pkg::MODE_CONV_1X1,
                                  conv_acc_pkg::MODE_CONV_3X3,
                                  conv_acc_pkg::MODE_MAX_POOL};
  assign accept  = start_i && !busy_q && mode_ok;

  // Start decode sees the live mode while routing uses the latched one
  assign start_1x1_o  = accept && (mode_i == conv_acc_pkg::MODE_CONV_1X1);
  assign start_3x3_o  = accept && (mode_i == conv_acc_pkg::MODE_CONV_3X3);
  assign start_pool_o = accept && (mode_i == conv_acc_pkg::MODE_MAX_POOL);

  always_comb begin
    sel_req  = '0;
    finish_o = 1'b0;
    if (busy_q) begin
      case (mode_q)
        conv_acc_pkg::MODE_CONV_1X1: begin
          sel_req  = req_1x1_i;
          finish_o = finish_1x1_i;
        end
        conv_acc_pkg::MODE_CONV_3X3: begin
          sel_req  = req_3x3_i;
          finish_o = finish_3x3_i;
        end
        conv_acc_pkg::MODE_MAX_POOL: begin
          sel_req  = req_pool_i;
          finish_o = finish_pool_i;
        end
        default: begin
          sel_req  = '0;
          finish_o = 1'b0;
        end
      endcase
    end
  end

  assign bias_req_o   = sel_req.bias;
  assign weight_req_o = sel_req.weight;
  assign in_req_o     = sel_req.ifm;
  assign out_req_o    = sel_req.ofm;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      mode_q <= conv_acc_pkg::MODE_CONV_1X1;
    end else if (accept) begin
      busy_q <= 1'b1;
      mode_q <= mode_i;
    end else if (finish_o) begin
      busy_q <= 1'b0;
    end
  end

  // One memory access per cycle at most
  a_one_access: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({bias_req_o.en, weight_req_o.en, in_req_o.en, out_req_o.en}));

endmodule

/* source/conv_acc.sv */
module conv_acc #(
  parameter int IMG_W = 6,
  parameter int IMG_H = 6
) (
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  logic                               start_i,
  input  conv_acc_pkg::acc_mode_e            mode_i,
  input  logic [31:0]                        w8_i,
  output conv_acc_pkg::mem_req_t             bias_req_o,
  output conv_acc_pkg::mem_req_t             weight_req_o,
  output conv_acc_pkg::mem_req_t             in_req_o,
  output conv_acc_pkg::mem_req_t             out_req_o,
  input  logic [conv_acc_pkg::OUT_W-1:0]     bias_rdata_i,
  input  logic [conv_acc_pkg::OUT_W-1:0]     weight_rdata_i,
  input  logic [conv_acc_pkg::OUT_W-1:0]     in_rdata_i,
  output logic                               finish_o
);

  logic start_1x1;
  logic start_3x3;
  logic start_pool;
  logic finish_1x1;
  logic finish_3x3;
  logic finish_pool;
  conv_acc_pkg::eng_req_t req_1x1;
  conv_acc_pkg::eng_req_t req_3x3;
  conv_acc_pkg::eng_req_t req_pool;

  accel_router i_accel_router (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .start_i       (start_i),
    .mode_i        (mode_i),
    .start_1x1_o   (start_1x1),
    .start_3x3_o   (start_3x3),
    .start_pool_o  (start_pool),
    .finish_1x1_i  (finish_1x1),
    .finish_3x3_i  (finish_3x3),
    .finish_pool_i (finish_pool),
    .req_1x1_i     (req_1x1),
    .req_3x3_i     (req_3x3),
    .req_pool_i    (req_pool),
    .bias_req_o    (bias_req_o),
    .weight_req_o  (weight_req_o),
    .in_req_o      (in_req_o),
    .out_req_o     (out_req_o),
    .finish_o      (finish_o)
  );

  conv_3x3 #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) i_conv_3x3 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .start_i        (start_3x3),
    .finish_o       (finish_3x3),
    .req_o          (req_3x3),
    .bias_rdata_i   (bias_rdata_i),
    .weight_rdata_i (weight_rdata_i),
    .in_rdata_i     (in_rdata_i)
  );

  conv_1x1 #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) i_conv_1x1 (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .start_i        (start_1x1),
    .w8_i           (w8_i),
    .finish_o       (finish_1x1),
    .req_o          (req_1x1),
    .bias_rdata_i   (bias_rdata_i),
    .weight_rdata_i (weight_rdata_i),
    .in_rdata_i     (in_rdata_i)
  );

  max_pool #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) i_max_pool (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (start_pool),
    .finish_o   (finish_pool),
    .req_o      (req_pool),
    .in_rdata_i (in_rdata_i)
  );

endmodule

/* source/max_pool.sv */
module max_pool #(
  parameter int IMG_W = 6,
  parameter int IMG_H = 6
) (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            start_i,
  output logic                            finish_o,
  output conv_acc_pkg::eng_req_t          req_o,
  input  logic [conv_acc_pkg::OUT_W-1:0]  in_rdata_i
);

  localparam int AW       = conv_acc_pkg::ADDR_W;
  localparam int PW       = conv_acc_pkg::PIX_W;
  localparam int OW       = conv_acc_pkg::OUT_W;
  localparam int OUT_COLS = IMG_W / 2;
  localparam int OUT_ROWS = IMG_H / 2;

  conv_acc_pkg::eng_state_e state_q;
  logic [1:0]               cnt_q;
  logic [1:0]               tap_d_q;
  logic                     rd_vld_q;
  logic [AW-1:0]            row_q;
  logic [AW-1:0]            col_q;
  logic signed [PW-1:0]     max_q;
  logic signed [PW-1:0]     pix;
  logic signed [PW-1:0]     cand;
  logic                     last_col;
  logic                     last_row;

  assign pix      = $signed(in_rdata_i[PW-1:0]);
  // First tap of a window overrides the stale maximum
  assign cand     = (tap_d_q == 2'd0 || pix > max_q) ? pix : max_q;
  assign last_col = (col_q == AW'(OUT_COLS - 1));
  assign last_row = (row_q == AW'(OUT_ROWS - 1));

  always_comb begin
    req_o = '0;
    case (state_q)
      conv_acc_pkg::ST_RUN: begin
        req_o.ifm.en   = 1'b1;
        req_o.ifm.addr = AW'((2 * row_q + cnt_q[1]) * IMG_W + 2 * col_q + cnt_q[0]);
      end
      conv_acc_pkg::ST_WRITE: begin
        req_o.ofm.en    = 1'b1;
        req_o.ofm.we    = 1'b1;
        req_o.ofm.addr  = AW'(row_q * OUT_COLS + col_q);
        req_o.ofm.wdata = {{(OW - PW){cand[PW-1]}}, cand};
      end
      default: req_o = '0;
    endcase
  end

  assign finish_o = (state_q == conv_acc_pkg::ST_DONE);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= conv_acc_pkg::ST_IDLE;
      cnt_q    <= '0;
      tap_d_q  <= '0;
      rd_vld_q <= 1'b0;
      row_q    <= '0;
      col_q    <= '0;
    end else begin
      rd_vld_q <= (state_q == conv_acc_pkg::ST_RUN);
      tap_d_q  <= cnt_q;
      case (state_q)
        conv_acc_pkg::ST_IDLE: begin
          if (start_i) begin
            state_q <= conv_acc_pkg::ST_RUN;
            cnt_q   <= '0;
            row_q   <= '0;
            col_q   <= '0;
          end
        end
        conv_acc_pkg::ST_RUN: begin
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == 2'd3) begin
            state_q <= conv_acc_pkg::ST_WRITE;
          end
        end
        conv_acc_pkg::ST_WRITE: begin
          if (last_col) begin
            col_q <= '0;
            row_q <= row_q + 1'b1;
          end else begin
            col_q <= col_q + 1'b1;
          end
          state_q <= (last_col && last_row) ? conv_acc_pkg::ST_DONE : conv_acc_pkg::ST_RUN;
        end
        default: state_q <= conv_acc_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_vld_q) begin
      max_q <= cand;
    end
  end

  // Each write follows the four reads of its window
  a_four_reads: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_o.ofm.en |-> $past(req_o.ifm.en, 1) && $past(req_o.ifm.en, 2)
                     && $past(req_o.ifm.en, 3) && $past(req_o.ifm.en, 4));

endmodule
